//--- hdl/nebula_pkg.sv
/* Bus types, address map and pad counts shared by the harness fabric.
   Every RTL module imports this package. */
`default_nettype none

package nebula_pkg;

    // Wishbone field widths
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // Manager request, held by the manager until ack
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_sel_t  sel;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // Target response
    typedef struct packed {
        logic     ack;   // One cycle per access
        wb_data_t dat;
    } wb_rsp_t;

    // Pads and analyzer bus
    localparam int NUM_PADS  = 38;
    localparam int LA_SLICES = 4;    // 32-bit slices of the analyzer bus

    typedef logic [NUM_PADS-1:0] gpio_vec_t;
    typedef logic [127:0]        la_vec_t;

    // Guest project number, 15 means unassigned
    typedef logic [3:0] proj_id_t;

    // Address map, one page per target
    localparam int PAGE_MSB = 31;
    localparam int PAGE_LSB = 24;

    typedef logic [PAGE_MSB-PAGE_LSB:0] page_t;

    localparam page_t PAGE_SRAM = 8'h30;
    localparam page_t PAGE_GPIO = 8'h31;
    localparam page_t PAGE_LA   = 8'h32;

endpackage

`default_nettype wire

//--- hdl/wb_decoder.sv
/* Page decoder: routes the strobe to one target and returns its response.
   Unmapped pages are answered here with zero data so the bus never hangs. */
`default_nettype none

module wb_decoder (
    input  wire                 wb_clk_i,
    input  wire                 rst_n_i,

    input  wire  nebula_pkg::wb_req_t bus_req_i,
    output nebula_pkg::wb_rsp_t       bus_rsp_o,

    output nebula_pkg::wb_req_t       sram_req_o,
    input  wire  nebula_pkg::wb_rsp_t sram_rsp_i,
    output nebula_pkg::wb_req_t       gpio_req_o,
    input  wire  nebula_pkg::wb_rsp_t gpio_rsp_i,
    output nebula_pkg::wb_req_t       la_req_o,
    input  wire  nebula_pkg::wb_rsp_t la_rsp_i
);
    import nebula_pkg::*;

    page_t page;
    logic  valid;
    logic  hit_sram, hit_gpio, hit_la, hit_none;
    logic  unmap_ack_q;

    // Copy of the request with the handshake kept only for the hit target
    function automatic wb_req_t gate_req(input wb_req_t req, input logic hit);
        wb_req_t gated;
        gated     = req;
        gated.cyc = req.cyc & hit;
        gated.stb = req.stb & hit;
        return gated;
    endfunction

    assign page     = bus_req_i.adr[PAGE_MSB:PAGE_LSB];
    assign valid    = bus_req_i.cyc & bus_req_i.stb;
    assign hit_sram = (page == PAGE_SRAM);
    assign hit_gpio = (page == PAGE_GPIO);
    assign hit_la   = (page == PAGE_LA);
    assign hit_none = ~(hit_sram | hit_gpio | hit_la);

    assign sram_req_o = gate_req(bus_req_i, hit_sram);
    assign gpio_req_o = gate_req(bus_req_i, hit_gpio);
    assign la_req_o   = gate_req(bus_req_i, hit_la);

    // Same one-cycle ack timing as the real targets
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            unmap_ack_q <= 1'b0;
        end else begin
            unmap_ack_q <= valid & hit_none & ~unmap_ack_q;
        end
    end

    // Address is held through the ack cycle, so the page still selects the source
    always_comb begin
        if (hit_sram) begin
            bus_rsp_o = sram_rsp_i;
        end else if (hit_gpio) begin
            bus_rsp_o = gpio_rsp_i;
        end else if (hit_la) begin
            bus_rsp_o = la_rsp_i;
        end else begin
            bus_rsp_o = '{ack: unmap_ack_q, dat: '0};   // Unmapped reads zero
        end
    end

    // Only the strobed target may answer
    a_one_ack: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $onehot0({sram_rsp_i.ack, gpio_rsp_i.ack, la_rsp_i.ack, unmap_ack_q}))
        else $error("more than one target acknowledged");

    // Every target must release ack after a single cycle
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        bus_rsp_o.ack |=> !bus_rsp_o.ack)
        else $error("ack held high for two cycles");

endmodule

`default_nettype wire

//--- hdl/wb_sram.sv
/* Word-addressed Wishbone SRAM with byte-lane writes.
   Read data is registered and valid in the ack cycle. */
`default_nettype none

module wb_sram #(
    parameter int SRAM_WORDS = 256   // Power of two
) (
    input  wire                       wb_clk_i,
    input  wire                       rst_n_i,
    input  wire  nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t       rsp_o
);
    import nebula_pkg::*;

    localparam int IDX_W = $clog2(SRAM_WORDS);
    localparam int LANES = $bits(wb_sel_t);

    typedef logic [IDX_W-1:0] word_idx_t;

    wb_data_t  mem_q [SRAM_WORDS];
    wb_data_t  rdata_q;
    word_idx_t idx;
    logic      access;
    logic      ack_q;

    // Upper address bits are dropped, so the array wraps
    assign idx    = req_i.adr[IDX_W+1:2];
    assign access = req_i.cyc & req_i.stb & ~ack_q;   // First cycle of a transfer

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access && req_i.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (req_i.sel[b]) begin
                    mem_q[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
        end
        if (access && !req_i.we) begin
            rdata_q <= mem_q[idx];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

//--- hdl/gpio_pin_mux.sv
/* Pad multiplexer: a 4-bit owner field per pad, eight fields per register.
   Each pad drives the out and oeb bits of its owning guest project. */
`default_nettype none

module gpio_pin_mux #(
    parameter int NUM_PROJECTS = 8
) (
    input  wire                                            wb_clk_i,
    input  wire                                            rst_n_i,
    input  wire  nebula_pkg::wb_req_t                      req_i,
    output nebula_pkg::wb_rsp_t                            rsp_o,

    input  wire  nebula_pkg::gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_out_i,
    input  wire  nebula_pkg::gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_oeb_i,
    output nebula_pkg::gpio_vec_t                          io_out_o,
    output nebula_pkg::gpio_vec_t                          io_oeb_o
);
    import nebula_pkg::*;

    localparam int PADS_PER_REG = $bits(wb_data_t) / $bits(proj_id_t);

    proj_id_t   owner_q [NUM_PADS];
    logic [2:0] reg_idx;
    logic       access;
    logic       ack_q;
    wb_data_t   rd_word;
    wb_data_t   rdata_q;

    assign reg_idx = req_i.adr[4:2];
    assign access  = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int p = 0; p < NUM_PADS; p++) begin
                owner_q[p] <= 4'hf;   // Unassigned
            end
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                // Registers 5 to 7 hold no pads and never match
                for (int p = 0; p < NUM_PADS; p++) begin
                    if (reg_idx == 3'(p / PADS_PER_REG) &&
                        req_i.sel[(p % PADS_PER_REG) / 2]) begin
                        owner_q[p] <= req_i.dat[4*(p % PADS_PER_REG) +: 4];
                    end
                end
            end
        end
    end

    // Fields of missing pads stay zero
    always_comb begin
        rd_word = '0;
        for (int p = 0; p < NUM_PADS; p++) begin
            if (reg_idx == 3'(p / PADS_PER_REG)) begin
                rd_word[4*(p % PADS_PER_REG) +: 4] = owner_q[p];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    // Pad selection, unowned pads are tri-stated with out low
    always_comb begin
        for (int p = 0; p < NUM_PADS; p++) begin
            if (owner_q[p] < NUM_PROJECTS) begin
                io_out_o[p] = proj_gpio_out_i[owner_q[p]][p];
                io_oeb_o[p] = proj_gpio_oeb_i[owner_q[p]][p];
            end else begin
                io_out_o[p] = 1'b0;
                io_oeb_o[p] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/la_mux.sv
/* Analyzer multiplexer: each 32-bit slice of the analyzer bus is taken
   from the guest project named in its owner register. */
`default_nettype none

module la_mux #(
    parameter int NUM_PROJECTS = 8
) (
    input  wire                                          wb_clk_i,
    input  wire                                          rst_n_i,
    input  wire  nebula_pkg::wb_req_t                    req_i,
    output nebula_pkg::wb_rsp_t                          rsp_o,

    input  wire  nebula_pkg::la_vec_t [NUM_PROJECTS-1:0] proj_la_i,
    output nebula_pkg::la_vec_t                          la_data_o
);
    import nebula_pkg::*;

    localparam int SLICE_W = $bits(la_vec_t) / LA_SLICES;

    proj_id_t                       owner_q [LA_SLICES];
    logic [$clog2(LA_SLICES)-1:0]   reg_idx;   // Address bits 3:2
    logic                           access;
    logic                           ack_q;
    wb_data_t                       rdata_q;

    assign reg_idx = req_i.adr[3:2];
    assign access  = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int s = 0; s < LA_SLICES; s++) begin
                owner_q[s] <= '0;
            end
        end else begin
            ack_q <= access;
            if (access && req_i.we && req_i.sel[0]) begin   // Lane 0 only
                owner_q[reg_idx] <= req_i.dat[3:0];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= wb_data_t'(owner_q[reg_idx]);
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    always_comb begin
        for (int s = 0; s < LA_SLICES; s++) begin
            if (owner_q[s] < NUM_PROJECTS) begin
                la_data_o[SLICE_W*s +: SLICE_W] = proj_la_i[owner_q[s]][SLICE_W*s +: SLICE_W];
            end else begin
                la_data_o[SLICE_W*s +: SLICE_W] = '0;   // No such project
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/nebula_top.sv
/* Harness fabric top: one Wishbone port from the management core to the
   SRAM, the pad multiplexer and the analyzer multiplexer. */
`default_nettype none

module nebula_top #(
    parameter int NUM_PROJECTS = 8,    // Guest projects, 1 to 15
    parameter int SRAM_WORDS   = 256   // Power of two
) (
    input  wire                                           wb_clk_i,
    input  wire                                           rst_n_i,

    // Management Wishbone port
    input  wire  nebula_pkg::wb_req_t                     bus_req_i,
    output nebula_pkg::wb_rsp_t                           bus_rsp_o,

    // Guest project outputs, indexed by project number
    input  wire  nebula_pkg::gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_out_i,
    input  wire  nebula_pkg::gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_oeb_i,
    input  wire  nebula_pkg::la_vec_t   [NUM_PROJECTS-1:0] proj_la_i,

    // Chip pads and analyzer bus
    output nebula_pkg::gpio_vec_t                         io_out_o,
    output nebula_pkg::gpio_vec_t                         io_oeb_o,   // Active low enable
    output nebula_pkg::la_vec_t                           la_data_o
);
    import nebula_pkg::*;

    wb_req_t sram_req, gpio_req, la_req;   // Gated copies of the manager request
    wb_rsp_t sram_rsp, gpio_rsp, la_rsp;

    wb_decoder i_decoder (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .bus_req_i  (bus_req_i),
        .bus_rsp_o  (bus_rsp_o),
        .sram_req_o (sram_req),
        .sram_rsp_i (sram_rsp),
        .gpio_req_o (gpio_req),
        .gpio_rsp_i (gpio_rsp),
        .la_req_o   (la_req),
        .la_rsp_i   (la_rsp)
    );

    wb_sram #(
        .SRAM_WORDS (SRAM_WORDS)
    ) i_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (sram_req),
        .rsp_o    (sram_rsp)
    );

    gpio_pin_mux #(
        .NUM_PROJECTS (NUM_PROJECTS)
    ) i_gpio_mux (
        .wb_clk_i        (wb_clk_i),
        .rst_n_i         (rst_n_i),
        .req_i           (gpio_req),
        .rsp_o           (gpio_rsp),
        .proj_gpio_out_i (proj_gpio_out_i),
        .proj_gpio_oeb_i (proj_gpio_oeb_i),
        .io_out_o        (io_out_o),
        .io_oeb_o        (io_oeb_o)
    );

    la_mux #(
        .NUM_PROJECTS (NUM_PROJECTS)
    ) i_la_mux (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (la_req),
        .rsp_o     (la_rsp),
        .proj_la_i (proj_la_i),
        .la_data_o (la_data_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
/* Testbench clock and active-low reset, released on a rising edge. */
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/tb_checker.sv
/* Bus and pad monitor: keeps a shadow of the SRAM and the owner registers
   and compares read data, pads and analyzer bus against reference functions. */
`default_nettype none

module tb_checker #(
    parameter int NUM_PROJECTS = 8,
    parameter int SRAM_WORDS   = 256
) (
    input  wire                                            clk_i,
    input  wire                                            rst_n_i,
    input  wire  [2:0]                                     phase_i,
    input  wire  nebula_pkg::wb_req_t                      bus_req_i,
    input  wire  nebula_pkg::wb_rsp_t                      bus_rsp_i,
    input  wire  nebula_pkg::gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_out_i,
    input  wire  nebula_pkg::gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_oeb_i,
    input  wire  nebula_pkg::la_vec_t   [NUM_PROJECTS-1:0] proj_la_i,
    input  wire  nebula_pkg::gpio_vec_t                    io_out_i,
    input  wire  nebula_pkg::gpio_vec_t                    io_oeb_i,
    input  wire  nebula_pkg::la_vec_t                      la_data_i,
    output int                                             err_cnt_o,
    output int                                             read_cnt_o
);
    import nebula_pkg::*;

    wb_data_t sh_mem [SRAM_WORDS];
    proj_id_t sh_pad_owner [NUM_PADS];
    proj_id_t sh_la_owner [LA_SLICES];
    logic     ack_prev;
    int       wait_cnt;   // Sampled request cycles without ack

    function automatic string phase_name(input logic [2:0] ph);
        case (ph)
            3'd0:    return "reset";
            3'd1:    return "sram";
            3'd2:    return "gpio";
            3'd3:    return "la";
            default: return "unmapped";
        endcase
    endfunction

    function automatic void mismatch(input string check, input logic [127:0] exp_v,
                                     input logic [127:0] act_v);
        $display("MISMATCH %s.%s expected %0h actual %0h", phase_name(phase_i), check,
                 exp_v, act_v);
        err_cnt_o++;
    endfunction

    function automatic void fault(input string text);
        $display("ERROR %s: %s", phase_name(phase_i), text);
        err_cnt_o++;
    endfunction

    function automatic int sram_index(input wb_addr_t adr);
        return int'((adr >> 2) % SRAM_WORDS);
    endfunction

    // Only selected byte lanes take the new data
    function automatic wb_data_t merge_lanes(input wb_data_t old_w, input wb_data_t new_w,
                                             input wb_sel_t sel);
        wb_data_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    function automatic void shadow_write(input wb_req_t req);
        int pad;
        case (req.adr[31:24])
            PAGE_SRAM: sh_mem[sram_index(req.adr)] =
                merge_lanes(sh_mem[sram_index(req.adr)], req.dat, req.sel);
            PAGE_GPIO: begin
                for (int j = 0; j < 8; j++) begin
                    pad = 8 * int'(req.adr[4:2]) + j;   // Eight pads per register
                    if (pad < NUM_PADS && req.sel[j / 2]) sh_pad_owner[pad] = req.dat[4*j +: 4];
                end
            end
            PAGE_LA: if (req.sel[0]) sh_la_owner[req.adr[3:2]] = req.dat[3:0];
            default: ;   // Unmapped writes are dropped
        endcase
    endfunction

    function automatic wb_data_t read_ref(input wb_addr_t adr);
        wb_data_t w;
        int       pad;
        w = '0;
        case (adr[31:24])
            PAGE_SRAM: w = sh_mem[sram_index(adr)];
            PAGE_GPIO: begin
                for (int j = 0; j < 8; j++) begin
                    pad = 8 * int'(adr[4:2]) + j;
                    if (pad < NUM_PADS) w[4*j +: 4] = sh_pad_owner[pad];
                end
            end
            PAGE_LA:   w[3:0] = sh_la_owner[adr[3:2]];
            default:   w = '0;
        endcase
        return w;
    endfunction

    function automatic gpio_vec_t pad_ref(input logic want_oeb);
        gpio_vec_t v;
        for (int p = 0; p < NUM_PADS; p++) begin
            if (int'(sh_pad_owner[p]) < NUM_PROJECTS) begin
                v[p] = want_oeb ? proj_gpio_oeb_i[sh_pad_owner[p]][p]
                                : proj_gpio_out_i[sh_pad_owner[p]][p];
            end else begin
                v[p] = want_oeb;   // Unassigned pad drives out 0 and oeb 1
            end
        end
        return v;
    endfunction

    function automatic la_vec_t la_ref();
        la_vec_t v;
        v = '0;
        for (int s = 0; s < LA_SLICES; s++) begin
            if (int'(sh_la_owner[s]) < NUM_PROJECTS) begin
                v[32*s +: 32] = proj_la_i[sh_la_owner[s]][32*s +: 32];
            end
        end
        return v;
    endfunction

    always @(posedge clk_i) begin
        wb_data_t exp_w;
        logic     valid;
        valid = bus_req_i.cyc & bus_req_i.stb;
        if (!rst_n_i) begin
            for (int p = 0; p < NUM_PADS; p++) sh_pad_owner[p] = 4'hf;
            for (int s = 0; s < LA_SLICES; s++) sh_la_owner[s] = 4'h0;
            ack_prev = 1'b0;
            wait_cnt = 0;
        end else begin
            if (bus_rsp_i.ack) begin
                if (ack_prev) fault("ack stayed high for two cycles");
                else if (!valid) fault("ack without a pending request");
                else if (wait_cnt != 1)
                    fault($sformatf("ack came %0d cycles after the request", wait_cnt));
                if (valid && !ack_prev) begin
                    if (bus_req_i.we) begin
                        shadow_write(bus_req_i);
                    end else begin
                        read_cnt_o++;
                        exp_w = read_ref(bus_req_i.adr);
                        if (bus_rsp_i.dat !== exp_w) mismatch("read", exp_w, bus_rsp_i.dat);
                    end
                end
                wait_cnt = 0;
            end else if (valid) begin
                wait_cnt++;
                if (wait_cnt == 4) fault($sformatf("no ack for address %h", bus_req_i.adr));
            end else begin
                wait_cnt = 0;
            end
            ack_prev = bus_rsp_i.ack;
            // Owner writes already show in the ack cycle
            if (io_out_i !== pad_ref(1'b0)) mismatch("pad_out", pad_ref(1'b0), io_out_i);
            if (io_oeb_i !== pad_ref(1'b1)) mismatch("pad_oeb", pad_ref(1'b1), io_oeb_i);
            if (la_data_i !== la_ref()) mismatch("la_data", la_ref(), la_data_i);
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_nebula.sv
/* Testbench top for the harness fabric. Drives Wishbone transfers and random
   guest-project outputs, tb_checker does the comparing. */
`default_nettype none

module tb_nebula;
    import nebula_pkg::*;

    localparam int NUM_PROJECTS = 8;
    localparam int SRAM_WORDS   = 256;

    localparam logic [2:0] PH_RESET    = 3'd0;
    localparam logic [2:0] PH_SRAM     = 3'd1;
    localparam logic [2:0] PH_GPIO     = 3'd2;
    localparam logic [2:0] PH_LA       = 3'd3;
    localparam logic [2:0] PH_UNMAPPED = 3'd4;

    // Loop counts that also size the watchdog
    localparam int N_SRAM_RND = 64;
    localparam int N_WRAP     = 8;
    localparam int N_GPIO_RND = 3;
    localparam int N_LA_RND   = 6;
    localparam int N_UNMAPPED = 8;
    localparam int NUM_TXNS   = SRAM_WORDS + 2 * N_SRAM_RND + 2 * N_WRAP + 16 * N_GPIO_RND +
                                8 * N_LA_RND + 3 * N_UNMAPPED + 9;
    localparam int WATCHDOG_CYCLES = NUM_TXNS * 20 + 200;

    logic                         clk;
    logic                         rst_n;
    logic [2:0]                   phase;
    wb_req_t                      bus_req;
    wb_rsp_t                      bus_rsp;
    gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_out;
    gpio_vec_t [NUM_PROJECTS-1:0] proj_gpio_oeb;
    la_vec_t   [NUM_PROJECTS-1:0] proj_la;
    gpio_vec_t                    io_out;
    gpio_vec_t                    io_oeb;
    la_vec_t                      la_data;
    int                           err_cnt;
    int                           read_cnt;

    tb_clkgen #(.PERIOD(8), .RESET_CYCLES(8)) i_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    nebula_top #(
        .NUM_PROJECTS (NUM_PROJECTS),
        .SRAM_WORDS   (SRAM_WORDS)
    ) i_dut (
        .wb_clk_i (clk), .rst_n_i (rst_n), .bus_req_i (bus_req), .bus_rsp_o (bus_rsp),
        .proj_gpio_out_i (proj_gpio_out), .proj_gpio_oeb_i (proj_gpio_oeb), .proj_la_i (proj_la),
        .io_out_o (io_out), .io_oeb_o (io_oeb), .la_data_o (la_data)
    );

    tb_checker #(
        .NUM_PROJECTS (NUM_PROJECTS),
        .SRAM_WORDS   (SRAM_WORDS)
    ) i_checker (
        .clk_i (clk), .rst_n_i (rst_n), .phase_i (phase), .bus_req_i (bus_req),
        .bus_rsp_i (bus_rsp), .proj_gpio_out_i (proj_gpio_out), .proj_gpio_oeb_i (proj_gpio_oeb),
        .proj_la_i (proj_la), .io_out_i (io_out), .io_oeb_i (io_oeb), .la_data_i (la_data),
        .err_cnt_o (err_cnt), .read_cnt_o (read_cnt)
    );

    function automatic wb_addr_t page_addr(input page_t page, input int offset);
        return {page, offset[23:0]};
    endfunction

    function automatic wb_data_t fill_word(input int idx);
        return (wb_data_t'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic page_t unmapped_page(input int i);
        case (i % 4)
            0:       return 8'h00;
            1:       return 8'h33;
            2:       return 8'h2f;
            default: return 8'hff;
        endcase
    endfunction

    task automatic set_phase(input logic [2:0] ph);
        @(posedge clk);
        phase <= ph;
    endtask

    task automatic new_project_patterns(input bit at_edge);
        gpio_vec_t [NUM_PROJECTS-1:0] outs;
        gpio_vec_t [NUM_PROJECTS-1:0] oebs;
        la_vec_t   [NUM_PROJECTS-1:0] las;
        for (int p = 0; p < NUM_PROJECTS; p++) begin
            outs[p] = gpio_vec_t'({$urandom(), $urandom()});
            oebs[p] = gpio_vec_t'({$urandom(), $urandom()});
            las[p]  = {$urandom(), $urandom(), $urandom(), $urandom()};
        end
        if (at_edge) @(posedge clk);
        proj_gpio_out <= outs;
        proj_gpio_oeb <= oebs;
        proj_la       <= las;
    endtask

    // Hold the request until ack, then release it on the next edge
    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                              input wb_sel_t sel);
        @(posedge clk);
        bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        do @(negedge clk); while (!bus_rsp.ack);
        @(posedge clk);
        bus_req <= '0;
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        bus_access(1'b1, adr, dat, sel);
    endtask

    task automatic bus_read(input wb_addr_t adr);
        bus_access(1'b0, adr, '0, 4'hf);
    endtask

    initial begin
        int       idx;
        wb_sel_t  sel;
        wb_addr_t adr;
        void'($urandom(79516));
        bus_req = '0;
        phase   = PH_RESET;
        new_project_patterns(1'b0);
        @(posedge rst_n);
        repeat (4) @(posedge clk);   // Reset state of pads and analyzer bus

        set_phase(PH_SRAM);
        for (int i = 0; i < SRAM_WORDS; i++) begin
            bus_write(page_addr(PAGE_SRAM, 4 * i), fill_word(i), 4'hf);
        end
        for (int i = 0; i < N_SRAM_RND; i++) begin
            idx = int'($urandom_range(SRAM_WORDS - 1));
            sel = wb_sel_t'($urandom());
            bus_write(page_addr(PAGE_SRAM, 4 * idx), $urandom(), sel);
            new_project_patterns(1'b1);
            bus_read(page_addr(PAGE_SRAM, 4 * idx));
        end
        for (int i = 0; i < N_WRAP; i++) begin   // Aliased word indices wrap around
            idx = int'($urandom_range(SRAM_WORDS - 1));
            bus_write(page_addr(PAGE_SRAM, 4 * (idx + SRAM_WORDS * (1 + i % 3))), $urandom(), 4'hf);
            bus_read(page_addr(PAGE_SRAM, 4 * idx));
        end

        set_phase(PH_GPIO);
        for (int k = 0; k < N_GPIO_RND; k++) begin
            for (int r = 0; r < 8; r++) begin
                sel = (k == 0) ? 4'hf : wb_sel_t'($urandom());
                bus_write(page_addr(PAGE_GPIO, 4 * r), $urandom(), sel);
                new_project_patterns(1'b1);
            end
            for (int r = 0; r < 8; r++) bus_read(page_addr(PAGE_GPIO, 4 * r));
        end

        set_phase(PH_LA);
        for (int k = 0; k < N_LA_RND; k++) begin
            for (int s = 0; s < 4; s++) begin
                sel = (k == 0) ? 4'hf : wb_sel_t'($urandom());
                bus_write(page_addr(PAGE_LA, 4 * s), $urandom(), sel);
                new_project_patterns(1'b1);
            end
            for (int s = 0; s < 4; s++) bus_read(page_addr(PAGE_LA, 4 * s));
        end

        set_phase(PH_UNMAPPED);
        for (int i = 0; i < N_UNMAPPED; i++) begin
            adr = page_addr(unmapped_page(i), int'($urandom() & 32'h00ff_fffc));
            bus_write(adr, $urandom(), 4'hf);
            bus_read(adr);
            // SRAM word at the same offset keeps its data
            bus_read(page_addr(PAGE_SRAM, int'(adr[23:0])));
        end
        // Owners must be untouched by the unmapped writes
        for (int r = 0; r < 5; r++) bus_read(page_addr(PAGE_GPIO, 4 * r));
        for (int s = 0; s < 4; s++) bus_read(page_addr(PAGE_LA, 4 * s));

        repeat (4) @(posedge clk);
        $display("Done: %0d errors, %0d reads compared", err_cnt, read_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES + 8) @(posedge clk);
        $display("Timeout after %0d cycles: %0d errors, %0d reads compared",
                 WATCHDOG_CYCLES, err_cnt, read_cnt);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- nebula_top.f
hdl/nebula_pkg.sv
hdl/wb_decoder.sv
hdl/wb_sram.sv
hdl/gpio_pin_mux.sv
hdl/la_mux.sv
hdl/nebula_top.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/tb_nebula.sv

//--- Makefile
# Verilator build and run of the harness fabric testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_nebula \
		-f nebula_top.f -Mdir obj_dir -o Vtb_nebula

run: compile
	./obj_dir/Vtb_nebula 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
